// File: rtl/biu_defs.svh
`ifndef BIU_DEFS_SVH
`define BIU_DEFS_SVH

// bus widths
`define BIU_ADDR_W 32
`define BIU_DATA_W 32
`define BIU_ID_W   4

// fixed AXI ids
// writes go out with the load/store id
`define BIU_IFU_ID 0
`define BIU_LSU_ID 1

// cycles before a missing write response is reported
`define BIU_B_TIMEOUT 64

`endif

// File: rtl/biu_pkg.sv
`default_nettype none

`include "biu_defs.svh"

package biu_pkg;

   typedef logic [`BIU_ADDR_W-1:0]   biu_addr_t;
   typedef logic [`BIU_DATA_W-1:0]   biu_data_t;
   typedef logic [`BIU_DATA_W/8-1:0] biu_strb_t;
   typedef logic [`BIU_ID_W-1:0]     biu_id_t;

   typedef enum logic [1:0] {
      AXI_OKAY   = 2'b00,
      AXI_EXOKAY = 2'b01,
      AXI_SLVERR = 2'b10,
      AXI_DECERR = 2'b11
   } axi_resp_e;

   // payload of the AR and AW channels
   typedef struct packed {
      biu_id_t    id;
      biu_addr_t  addr;
      logic [2:0] prot;
   } axi_addr_req_t;

   typedef struct packed {
      biu_data_t data;
      biu_strb_t strb;
   } axi_wbeat_t;

   typedef enum logic [1:0] {IDLE, SEND, WAIT_B, DRAIN} wr_state_e;

endpackage

`default_nettype wire

// File: rtl/biu_chan_reg.sv
`timescale 1ns/1ps
`default_nettype none

module biu_chan_reg #(
   parameter type payload_t = logic
) (
   input  wire      clk,
   input  wire      rst_n,
   input  wire      in_valid,
   output logic     in_ready,
   input  wire      payload_t in_payload,
   output logic     out_valid,
   input  wire      out_ready,
   output payload_t out_payload
);

   logic full;
   logic take;

   // a full entry frees up in the cycle it is handed over
   assign in_ready  = ~full | out_ready;
   assign take      = in_valid & in_ready;
   assign out_valid = full;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         full <= 1'b0;
      end else if (take) begin
         full <= 1'b1;
      end else if (out_ready) begin
         full <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (take) begin
         out_payload <= in_payload;
      end
   end

endmodule

`default_nettype wire

// File: rtl/biu_rd_router.sv
`timescale 1ns/1ps
`default_nettype none

`include "biu_defs.svh"

module biu_rd_router (
   input  wire                     clk,
   input  wire                     rst_n,
   input  wire                     ifu_rd_req,
   input  wire biu_pkg::biu_addr_t ifu_rd_addr,
   input  wire                     ifu_cancel,
   output logic                    ifu_rd_ack,
   output logic                    ifu_data_valid,
   output biu_pkg::biu_data_t      ifu_data,
   input  wire                     lsu_rd_req,
   input  wire biu_pkg::biu_addr_t lsu_rd_addr,
   output logic                    lsu_rd_ack,
   output logic                    lsu_data_valid,
   output biu_pkg::biu_data_t      lsu_data,
   output logic                    ar_valid,
   input  wire                     ar_ready,
   output biu_pkg::axi_addr_req_t  ar_payload,
   input  wire                     r_valid,
   output logic                    r_ready,
   input  wire biu_pkg::biu_id_t   r_id,
   input  wire biu_pkg::biu_data_t r_data
);

   import biu_pkg::*;

   localparam biu_id_t IFU_ID = biu_id_t'(`BIU_IFU_ID);
   localparam biu_id_t LSU_ID = biu_id_t'(`BIU_LSU_ID);

   logic ifu_busy;
   logic lsu_busy;
   logic ifu_cancelled;
   logic lsu_last;
   logic ifu_can;
   logic lsu_can;
   logic grant_ifu;
   logic grant_lsu;
   logic r_hs;
   logic r_ifu;
   logic r_lsu;

   assign ifu_can = ifu_rd_req & ~ifu_busy;
   assign lsu_can = lsu_rd_req & ~lsu_busy;

   // on a tie the source not granted last time wins
   assign grant_ifu = ar_ready & ifu_can & (~lsu_can | lsu_last);
   assign grant_lsu = ar_ready & lsu_can & (~ifu_can | ~lsu_last);

   assign ifu_rd_ack = grant_ifu;
   assign lsu_rd_ack = grant_lsu;
   assign ar_valid   = grant_ifu | grant_lsu;

   always_comb begin
      if (grant_lsu) begin
         ar_payload.id   = LSU_ID;
         ar_payload.addr = lsu_rd_addr;
         ar_payload.prot = 3'b000;
      end else begin
         ar_payload.id   = IFU_ID;
         ar_payload.addr = ifu_rd_addr;
         // instruction access
         ar_payload.prot = 3'b100;
      end
   end

   assign r_ready = ifu_busy | lsu_busy;
   assign r_hs    = r_valid & r_ready;
   assign r_ifu   = r_hs & (r_id == IFU_ID);
   assign r_lsu   = r_hs & (r_id == LSU_ID);

   // a cancel in the beat's own cycle still drops it
   assign ifu_data_valid = r_ifu & ~ifu_cancelled & ~ifu_cancel;
   assign lsu_data_valid = r_lsu;
   assign ifu_data       = r_data;
   assign lsu_data       = r_data;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         ifu_busy      <= 1'b0;
         lsu_busy      <= 1'b0;
         ifu_cancelled <= 1'b0;
         lsu_last      <= 1'b0;
      end else begin
         if (grant_ifu) begin
            ifu_busy <= 1'b1;
         end else if (r_ifu) begin
            ifu_busy <= 1'b0;
         end
         if (grant_lsu) begin
            lsu_busy <= 1'b1;
         end else if (r_lsu) begin
            lsu_busy <= 1'b0;
         end
         if (r_ifu) begin
            ifu_cancelled <= 1'b0;
         end else if (ifu_cancel && ifu_busy) begin
            ifu_cancelled <= 1'b1;
         end
         if (grant_ifu) begin
            lsu_last <= 1'b0;
         end else if (grant_lsu) begin
            lsu_last <= 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

// File: rtl/biu_wr_fsm.sv
`timescale 1ns/1ps
`default_nettype none

`include "biu_defs.svh"

module biu_wr_fsm (
   input  wire                     clk,
   input  wire                     rst_n,
   input  wire                     lsu_wr_req,
   input  wire biu_pkg::biu_addr_t lsu_wr_addr,
   input  wire biu_pkg::biu_data_t lsu_wr_data,
   input  wire biu_pkg::biu_strb_t lsu_wr_strb,
   output logic                    lsu_wr_ack,
   output logic                    lsu_write_done,
   output logic                    lsu_wr_err,
   output logic                    aw_load,
   output biu_pkg::axi_addr_req_t  aw_payload,
   input  wire                     aw_free,
   output logic                    w_load,
   output biu_pkg::axi_wbeat_t     w_payload,
   input  wire                     w_free,
   input  wire                     b_valid,
   output logic                    b_ready,
   input  wire biu_pkg::axi_resp_e b_resp,
   output logic                    timer_start,
   output logic                    timer_run,
   input  wire                     timer_expired
);

   import biu_pkg::*;

   wr_state_e state;
   wr_state_e state_nxt;
   logic      sent;

   // both channel registers have handed their beat over
   assign sent = aw_free & w_free;

   always_comb begin
      state_nxt = state;
      case (state)
         IDLE:    if (lsu_wr_req) state_nxt = SEND;
         SEND:    if (sent) state_nxt = WAIT_B;
         WAIT_B: begin
            if (b_valid) begin
               state_nxt = IDLE;
            end else if (timer_expired) begin
               state_nxt = DRAIN;
            end
         end
         DRAIN:   if (b_valid) state_nxt = IDLE;
         default: state_nxt = IDLE;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state <= IDLE;
      end else begin
         state <= state_nxt;
      end
   end

   assign lsu_wr_ack = (state == IDLE) & lsu_wr_req;
   assign aw_load    = lsu_wr_ack;
   assign w_load     = lsu_wr_ack;

   always_comb begin
      aw_payload.id   = biu_id_t'(`BIU_LSU_ID);
      aw_payload.addr = lsu_wr_addr;
      aw_payload.prot = 3'b000;
      w_payload.data  = lsu_wr_data;
      w_payload.strb  = lsu_wr_strb;
   end

   // late responses are still taken in DRAIN
   assign b_ready     = (state == WAIT_B) | (state == DRAIN);
   assign timer_start = (state == SEND) & sent;
   assign timer_run   = (state == WAIT_B);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         lsu_write_done <= 1'b0;
         lsu_wr_err     <= 1'b0;
      end else begin
         lsu_write_done <= (state == WAIT_B) & (b_valid | timer_expired);
         lsu_wr_err     <= (state == WAIT_B) &
                           (b_valid ? (b_resp != AXI_OKAY) : timer_expired);
      end
   end

endmodule

`default_nettype wire

// File: rtl/biu_wait_timer.sv
`timescale 1ns/1ps
`default_nettype none

`include "biu_defs.svh"

module biu_wait_timer (
   input  wire  clk,
   input  wire  rst_n,
   input  wire  start,
   input  wire  run,
   output logic expired
);

   localparam int CNT_W = $clog2(`BIU_B_TIMEOUT + 1);

   logic [CNT_W-1:0] cnt;

   assign expired = (cnt == CNT_W'(`BIU_B_TIMEOUT));

   // holds at the limit once reached
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         cnt <= '0;
      end else if (start) begin
         cnt <= '0;
      end else if (run && !expired) begin
         cnt <= cnt + 1'b1;
      end
   end

endmodule

`default_nettype wire

// File: rtl/biu_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "biu_defs.svh"

module biu_top (
   input  wire                     clk,
   input  wire                     rst_n,

   // instruction fetch
   input  wire                     ifu_rd_req,
   input  wire biu_pkg::biu_addr_t ifu_rd_addr,
   input  wire                     ifu_cancel,
   output logic                    ifu_rd_ack,
   output logic                    ifu_data_valid,
   output biu_pkg::biu_data_t      ifu_data,

   // load/store
   input  wire                     lsu_rd_req,
   input  wire biu_pkg::biu_addr_t lsu_rd_addr,
   output logic                    lsu_rd_ack,
   output logic                    lsu_data_valid,
   output biu_pkg::biu_data_t      lsu_data,
   input  wire                     lsu_wr_req,
   input  wire biu_pkg::biu_addr_t lsu_wr_addr,
   input  wire biu_pkg::biu_data_t lsu_wr_data,
   input  wire biu_pkg::biu_strb_t lsu_wr_strb,
   output logic                    lsu_wr_ack,
   output logic                    lsu_write_done,
   output logic                    lsu_wr_err,

   // ar
   output biu_pkg::biu_id_t        arid,
   output biu_pkg::biu_addr_t      araddr,
   output logic [3:0]              arlen,
   output logic [2:0]              arsize,
   output logic [1:0]              arburst,
   output logic [1:0]              arlock,
   output logic [3:0]              arcache,
   output logic [2:0]              arprot,
   output logic                    arvalid,
   input  wire                     arready,

   // r
   input  wire biu_pkg::biu_id_t   rid,
   input  wire biu_pkg::biu_data_t rdata,
   input  wire [1:0]               rresp,
   input  wire                     rlast,
   input  wire                     rvalid,
   output logic                    rready,

   // aw
   output biu_pkg::biu_id_t        awid,
   output biu_pkg::biu_addr_t      awaddr,
   output logic [3:0]              awlen,
   output logic [2:0]              awsize,
   output logic [1:0]              awburst,
   output logic [1:0]              awlock,
   output logic [3:0]              awcache,
   output logic [2:0]              awprot,
   output logic                    awvalid,
   input  wire                     awready,

   // w
   output biu_pkg::biu_id_t        wid,
   output biu_pkg::biu_data_t      wdata,
   output biu_pkg::biu_strb_t      wstrb,
   output logic                    wlast,
   output logic                    wvalid,
   input  wire                     wready,

   // b
   input  wire biu_pkg::biu_id_t   bid,
   input  wire [1:0]               bresp,
   input  wire                     bvalid,
   output logic                    bready
);

   import biu_pkg::*;

   logic          ar_in_valid;
   logic          ar_in_ready;
   axi_addr_req_t ar_in_payload;
   axi_addr_req_t ar_out_payload;
   logic          aw_load;
   logic          aw_free;
   axi_addr_req_t aw_in_payload;
   axi_addr_req_t aw_out_payload;
   logic          w_load;
   logic          w_free;
   axi_wbeat_t    w_in_payload;
   axi_wbeat_t    w_out_payload;
   logic          timer_start;
   logic          timer_run;
   logic          timer_expired;

   biu_rd_router u_rd_router (
      .clk            (clk           ),
      .rst_n          (rst_n         ),
      .ifu_rd_req     (ifu_rd_req    ),
      .ifu_rd_addr    (ifu_rd_addr   ),
      .ifu_cancel     (ifu_cancel    ),
      .ifu_rd_ack     (ifu_rd_ack    ),
      .ifu_data_valid (ifu_data_valid),
      .ifu_data       (ifu_data      ),
      .lsu_rd_req     (lsu_rd_req    ),
      .lsu_rd_addr    (lsu_rd_addr   ),
      .lsu_rd_ack     (lsu_rd_ack    ),
      .lsu_data_valid (lsu_data_valid),
      .lsu_data       (lsu_data      ),
      .ar_valid       (ar_in_valid   ),
      .ar_ready       (ar_in_ready   ),
      .ar_payload     (ar_in_payload ),
      .r_valid        (rvalid        ),
      .r_ready        (rready        ),
      .r_id           (rid           ),
      .r_data         (rdata         )
   );

   biu_wr_fsm u_wr_fsm (
      .clk            (clk               ),
      .rst_n          (rst_n             ),
      .lsu_wr_req     (lsu_wr_req        ),
      .lsu_wr_addr    (lsu_wr_addr       ),
      .lsu_wr_data    (lsu_wr_data       ),
      .lsu_wr_strb    (lsu_wr_strb       ),
      .lsu_wr_ack     (lsu_wr_ack        ),
      .lsu_write_done (lsu_write_done    ),
      .lsu_wr_err     (lsu_wr_err        ),
      .aw_load        (aw_load           ),
      .aw_payload     (aw_in_payload     ),
      .aw_free        (aw_free           ),
      .w_load         (w_load            ),
      .w_payload      (w_in_payload      ),
      .w_free         (w_free            ),
      .b_valid        (bvalid            ),
      .b_ready        (bready            ),
      .b_resp         (axi_resp_e'(bresp)),
      .timer_start    (timer_start       ),
      .timer_run      (timer_run         ),
      .timer_expired  (timer_expired     )
   );

   biu_wait_timer u_b_timer (
      .clk     (clk          ),
      .rst_n   (rst_n        ),
      .start   (timer_start  ),
      .run     (timer_run    ),
      .expired (timer_expired)
   );

   biu_chan_reg #(.payload_t(axi_addr_req_t)) u_ar_reg (
      .clk         (clk           ),
      .rst_n       (rst_n         ),
      .in_valid    (ar_in_valid   ),
      .in_ready    (ar_in_ready   ),
      .in_payload  (ar_in_payload ),
      .out_valid   (arvalid       ),
      .out_ready   (arready       ),
      .out_payload (ar_out_payload)
   );

   biu_chan_reg #(.payload_t(axi_addr_req_t)) u_aw_reg (
      .clk         (clk           ),
      .rst_n       (rst_n         ),
      .in_valid    (aw_load       ),
      .in_ready    (aw_free       ),
      .in_payload  (aw_in_payload ),
      .out_valid   (awvalid       ),
      .out_ready   (awready       ),
      .out_payload (aw_out_payload)
   );

   biu_chan_reg #(.payload_t(axi_wbeat_t)) u_w_reg (
      .clk         (clk          ),
      .rst_n       (rst_n        ),
      .in_valid    (w_load       ),
      .in_ready    (w_free       ),
      .in_payload  (w_in_payload ),
      .out_valid   (wvalid       ),
      .out_ready   (wready       ),
      .out_payload (w_out_payload)
   );

   // single beat INCR word accesses only
   assign arid    = ar_out_payload.id;
   assign araddr  = ar_out_payload.addr;
   assign arprot  = ar_out_payload.prot;
   assign arlen   = 4'd0;
   assign arsize  = 3'd2;
   assign arburst = 2'b01;
   assign arlock  = 2'b00;
   assign arcache = 4'd0;

   assign awid    = aw_out_payload.id;
   assign awaddr  = aw_out_payload.addr;
   assign awprot  = aw_out_payload.prot;
   assign awlen   = 4'd0;
   assign awsize  = 3'd2;
   assign awburst = 2'b01;
   assign awlock  = 2'b00;
   assign awcache = 4'd0;

   assign wid     = biu_id_t'(`BIU_LSU_ID);
   assign wdata   = w_out_payload.data;
   assign wstrb   = w_out_payload.strb;
   assign wlast   = 1'b1;

endmodule

`default_nettype wire

// File: sim/axi_slave_model.sv
`timescale 1ns/1ps
`default_nettype none

module axi_slave_model (
   input  wire         clk,
   input  wire         rst_n,
   input  wire  [3:0]  rnd,
   input  wire         reorder,
   input  wire         b_err,
   input  wire         b_hold,
   output logic        b_busy,
   input  wire  [3:0]  arid,
   input  wire  [31:0] araddr,
   input  wire         arvalid,
   output logic        arready,
   output logic [3:0]  rid,
   output logic [31:0] rdata,
   output logic [1:0]  rresp,
   output logic        rlast,
   output logic        rvalid,
   input  wire         rready,
   input  wire  [31:0] awaddr,
   input  wire         awvalid,
   output logic        awready,
   input  wire  [31:0] wdata,
   input  wire  [3:0]  wstrb,
   input  wire         wvalid,
   output logic        wready,
   output logic [3:0]  bid,
   output logic [1:0]  bresp,
   output logic        bvalid,
   input  wire         bready
);

   logic [7:0] mem [0:1023];
   logic [1:0] rd_pend;
   logic [9:0] rd_a [0:1];
   logic       lsu_passed;
   logic       aw_got;
   logic       w_got;
   logic [9:0] aw_a;
   logic [31:0] w_d;
   logic [3:0] w_s;
   logic [7:0] bcnt;

   function automatic logic [31:0] word_at(input logic [9:0] a);
      return {mem[{a[9:2], 2'd3}], mem[{a[9:2], 2'd2}], mem[{a[9:2], 2'd1}], mem[{a[9:2], 2'd0}]};
   endfunction

   initial begin
      for (int i = 0; i < 1024; i++) begin
         mem[i] = 8'((i * 29) ^ (i >> 3));
      end
   end

   // random handshake delays
   assign arready = rnd[0];
   assign awready = rnd[1] & ~aw_got;
   assign wready  = rnd[2] & ~w_got;
   assign rresp   = 2'b00;
   assign rlast   = 1'b1;
   assign bid     = 4'd1;

   always @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rd_pend    <= 2'b00;
         lsu_passed <= 1'b0;
         rvalid     <= 1'b0;
         rid        <= 4'd0;
         rdata      <= 32'd0;
         aw_got     <= 1'b0;
         w_got      <= 1'b0;
         b_busy     <= 1'b0;
         bvalid     <= 1'b0;
         bresp      <= 2'b00;
         bcnt       <= 8'd0;
      end else begin
         if (!reorder) begin
            lsu_passed <= 1'b0;
         end
         if (rvalid && rready) begin
            rvalid           <= 1'b0;
            rd_pend[rid[0]]  <= 1'b0;
            if (rid[0]) begin
               lsu_passed <= 1'b1;
            end
         end else if (!rvalid && rnd[3]) begin
            // load reads go first, fetches wait for one when reordering
            if (rd_pend[1]) begin
               rvalid <= 1'b1;
               rid    <= 4'd1;
               rdata  <= word_at(rd_a[1]);
            end else if (rd_pend[0] && (!reorder || lsu_passed)) begin
               rvalid <= 1'b1;
               rid    <= 4'd0;
               rdata  <= word_at(rd_a[0]);
            end
         end
         if (arvalid && arready) begin
            rd_pend[arid[0]] <= 1'b1;
            rd_a[arid[0]]    <= araddr[9:0];
         end
         if (awvalid && awready) begin
            aw_got <= 1'b1;
            aw_a   <= awaddr[9:0];
         end
         if (wvalid && wready) begin
            w_got <= 1'b1;
            w_d   <= wdata;
            w_s   <= wstrb;
         end
         if (aw_got && w_got) begin
            for (int k = 0; k < 4; k++) begin
               if (w_s[k]) begin
                  mem[{aw_a[9:2], k[1:0]}] <= w_d[8*k +: 8];
               end
            end
            aw_got <= 1'b0;
            w_got  <= 1'b0;
            b_busy <= 1'b1;
            bcnt   <= b_hold ? 8'd100 : 8'd0;
            bresp  <= b_err ? 2'b10 : 2'b00;
         end
         if (bvalid && bready) begin
            bvalid <= 1'b0;
            b_busy <= 1'b0;
         end else if (b_busy && !bvalid && bcnt != 8'd0) begin
            bcnt <= bcnt - 8'd1;
         end else if (b_busy && !bvalid && rnd[3]) begin
            bvalid <= 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

// File: sim/biu_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "biu_defs.svh"

module biu_tb;

   import biu_pkg::*;

   localparam int N_RAND      = 40;
   localparam int N_TRANS     = 2 * N_RAND + 12;
   localparam int MAX_DELAY   = 16;
   localparam longint WDOG_NS = 2 * N_TRANS * (MAX_DELAY + `BIU_B_TIMEOUT) * 8;

   logic clk, rst_n;
   logic ifu_rd_req, ifu_cancel, ifu_rd_ack, ifu_data_valid;
   logic lsu_rd_req, lsu_rd_ack, lsu_data_valid;
   logic lsu_wr_req, lsu_wr_ack, lsu_write_done, lsu_wr_err;
   biu_addr_t ifu_rd_addr, lsu_rd_addr, lsu_wr_addr, araddr, awaddr;
   biu_data_t ifu_data, lsu_data, lsu_wr_data, rdata, wdata;
   biu_strb_t lsu_wr_strb, wstrb;
   biu_id_t arid, rid, awid, wid, bid;
   logic [3:0] arlen, arcache, awlen, awcache;
   logic [2:0] arsize, arprot, awsize, awprot;
   logic [1:0] arburst, arlock, awburst, awlock, rresp, bresp;
   logic arvalid, arready, rlast, rvalid, rready, awvalid, awready;
   logic wlast, wvalid, wready, bvalid, bready;
   logic [3:0] rnd;
   logic reorder, b_err, b_hold, b_busy;

   logic [16:0] lfsr_state = 17'd77453;
   logic [7:0]  ref_mem [0:1023];
   biu_data_t   ifu_exp[$];
   biu_data_t   lsu_exp[$];
   logic [2:0]  wr_exp[$];

   // reads in flight and write response owed, as seen on the bus
   int          rd_out  = 0;
   logic        b_owed  = 1'b0;
   logic        aw_seen = 1'b0;
   logic        w_seen  = 1'b0;

   biu_top UUT (.*);
   axi_slave_model u_slave (.*);

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   // galois form of x^17 + x^14 + 1
   function automatic logic lfsr_bit();
      logic b;
      b = lfsr_state[0];
      lfsr_state = lfsr_state >> 1;
      if (b) begin
         lfsr_state = lfsr_state ^ 17'h12000;
      end
      return b;
   endfunction

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = 32'd0;
      for (int i = 0; i < n; i++) begin
         v = {v[30:0], lfsr_bit()};
      end
      return v;
   endfunction

   // expected word from the modelled memory
   function automatic biu_data_t ref_word(input biu_addr_t a);
      return {ref_mem[{a[9:2], 2'd3}], ref_mem[{a[9:2], 2'd2}],
              ref_mem[{a[9:2], 2'd1}], ref_mem[{a[9:2], 2'd0}]};
   endfunction

   task automatic stop_run();
      $display("Done: errors found");
      $fatal(1);
   endtask

   task automatic check_data(input string name, input biu_data_t got, input biu_data_t exp);
      if (got !== exp) begin
         $display("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
         stop_run();
      end
   endtask

   task automatic check_resp(input logic got, input axi_resp_e injected, input logic held);
      logic exp;
      exp = held | (injected != AXI_OKAY);
      if (got !== exp) begin
         $display("Error at %0t ns: lsu_wr_err is %b, expected %b", $time, got, exp);
         stop_run();
      end
   endtask

   task automatic check_field(input string name, input logic [3:0] got,
                              input logic [3:0] exp);
      if (got !== exp) begin
         $display("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
         stop_run();
      end
   endtask

   task automatic unexpected(input string name);
      $display("a %s pulse came with no request waiting for it, at %0t ns", name, $time);
      stop_run();
   endtask

   task automatic wait_idle();
      while (ifu_exp.size() != 0 || lsu_exp.size() != 0 || wr_exp.size() != 0) begin
         @(negedge clk);
      end
   endtask

   task automatic ifu_read(input biu_addr_t a, input logic cancel);
      @(posedge clk);
      ifu_rd_req  <= 1'b1;
      ifu_rd_addr <= a;
      do @(negedge clk); while (!ifu_rd_ack);
      if (!cancel) begin
         ifu_exp.push_back(ref_word(a));
      end
      @(posedge clk);
      ifu_rd_req <= 1'b0;
      ifu_cancel <= cancel;
      @(posedge clk);
      ifu_cancel <= 1'b0;
   endtask

   task automatic lsu_read(input biu_addr_t a);
      @(posedge clk);
      lsu_rd_req  <= 1'b1;
      lsu_rd_addr <= a;
      do @(negedge clk); while (!lsu_rd_ack);
      lsu_exp.push_back(ref_word(a));
      @(posedge clk);
      lsu_rd_req <= 1'b0;
   endtask

   task automatic lsu_write(input biu_addr_t a, input biu_data_t d, input biu_strb_t s,
                            input axi_resp_e resp, input logic hold);
      @(posedge clk);
      lsu_wr_req  <= 1'b1;
      lsu_wr_addr <= a;
      lsu_wr_data <= d;
      lsu_wr_strb <= s;
      b_err       <= (resp == AXI_SLVERR);
      b_hold      <= hold;
      do @(negedge clk); while (!lsu_wr_ack);
      for (int k = 0; k < 4; k++) begin
         if (s[k]) begin
            ref_mem[{a[9:2], k[1:0]}] = d[8*k +: 8];
         end
      end
      wr_exp.push_back({hold, resp});
      @(posedge clk);
      lsu_wr_req <= 1'b0;
      wait_idle();
      b_err  <= 1'b0;
      b_hold <= 1'b0;
   endtask

   always @(posedge clk) begin
      rnd <= {lfsr_bit(), lfsr_bit(), lfsr_bit(), lfsr_bit()};
   end

   always @(negedge clk) begin
      logic [2:0] e;
      if (rst_n) begin
         if (ifu_data_valid) begin
            if (ifu_exp.size() == 0) unexpected("ifu_data_valid");
            else check_data("ifu_data", ifu_data, ifu_exp.pop_front());
         end
         if (lsu_data_valid) begin
            if (lsu_exp.size() == 0) unexpected("lsu_data_valid");
            else check_data("lsu_data", lsu_data, lsu_exp.pop_front());
         end
         if (lsu_write_done) begin
            if (wr_exp.size() == 0) begin
               unexpected("lsu_write_done");
            end else begin
               e = wr_exp.pop_front();
               check_resp(lsu_wr_err, axi_resp_e'(e[1:0]), e[2]);
            end
         end
         if (lsu_wr_ack && b_busy) begin
            $display("a write was acknowledged while a write response was still owed");
            stop_run();
         end
      end
   end

   // AXI side fixed fields and ready levels
   always @(negedge clk) begin
      if (rst_n) begin
         check_field("rready", {3'b000, rready}, {3'b000, rd_out != 0});
         check_field("bready", {3'b000, bready}, {3'b000, b_owed});
         if (arvalid) begin
            if (arid != biu_id_t'(`BIU_IFU_ID) && arid != biu_id_t'(`BIU_LSU_ID)) begin
               $display("a read went out with id %0d, which belongs to no source", arid);
               stop_run();
            end
            check_field("arlen", arlen, 4'd0);
            check_field("arsize", {1'b0, arsize}, 4'd2);
            check_field("arburst", {2'b00, arburst}, 4'd1);
            check_field("arlock", {2'b00, arlock}, 4'd0);
            check_field("arcache", arcache, 4'd0);
            // instruction bit only for fetches
            check_field("arprot[2]", {3'b000, arprot[2]},
                        {3'b000, arid == biu_id_t'(`BIU_IFU_ID)});
         end
         if (awvalid) begin
            check_field("awid", awid, biu_id_t'(`BIU_LSU_ID));
            check_field("awlen", awlen, 4'd0);
            check_field("awsize", {1'b0, awsize}, 4'd2);
            check_field("awburst", {2'b00, awburst}, 4'd1);
            check_field("awlock", {2'b00, awlock}, 4'd0);
            check_field("awcache", awcache, 4'd0);
            check_field("awprot[2]", {3'b000, awprot[2]}, 4'd0);
         end
         if (wvalid) begin
            check_field("wid", wid, biu_id_t'(`BIU_LSU_ID));
            check_field("wlast", {3'b000, wlast}, 4'd1);
         end
         rd_out = rd_out + int'(ifu_rd_ack) + int'(lsu_rd_ack) - int'(rvalid && rready);
         if (bvalid && bready) begin
            b_owed = 1'b0;
         end
         if (awvalid && awready) begin
            aw_seen = 1'b1;
         end
         if (wvalid && wready) begin
            w_seen = 1'b1;
         end
         // response owed once address and data have both gone out
         if (aw_seen && w_seen) begin
            b_owed  = 1'b1;
            aw_seen = 1'b0;
            w_seen  = 1'b0;
         end
      end
   end

   initial begin
      #(WDOG_NS);
      $display("watchdog expired at %0t ns, the run hung", $time);
      stop_run();
   end

   initial begin
      biu_addr_t   a;
      logic [31:0] r;
      int          op;
      for (int i = 0; i < 1024; i++) begin
         ref_mem[i] = 8'((i * 29) ^ (i >> 3));
      end
      rst_n       = 1'b0;
      ifu_rd_req  = 1'b0;
      ifu_rd_addr = '0;
      ifu_cancel  = 1'b0;
      lsu_rd_req  = 1'b0;
      lsu_rd_addr = '0;
      lsu_wr_req  = 1'b0;
      lsu_wr_addr = '0;
      lsu_wr_data = '0;
      lsu_wr_strb = '0;
      rnd         = 4'd0;
      reorder     = 1'b0;
      b_err       = 1'b0;
      b_hold      = 1'b0;
      repeat (10) @(posedge clk);
      rst_n <= 1'b1;

      ifu_read(32'h40, 1'b0);
      lsu_read(32'h84);
      wait_idle();

      // the load read is answered before the fetch
      reorder <= 1'b1;
      fork
         ifu_read(32'h100, 1'b0);
         lsu_read(32'h204);
      join
      wait_idle();
      reorder <= 1'b0;

      lsu_write(32'h300, 32'hcafef00d, 4'b0101, AXI_OKAY, 1'b0);
      lsu_read(32'h300);
      wait_idle();

      lsu_write(32'h310, 32'h12345678, 4'hf, AXI_SLVERR, 1'b0);
      lsu_write(32'h314, 32'h9abcdef0, 4'hf, AXI_OKAY, 1'b1);
      lsu_write(32'h318, 32'h0badf00d, 4'b1100, AXI_OKAY, 1'b0);
      lsu_read(32'h314);
      wait_idle();

      ifu_read(32'h140, 1'b1);
      ifu_read(32'h144, 1'b0);
      wait_idle();

      for (int n = 0; n < N_RAND; n++) begin
         op = int'(rand_bits(2));
         r  = rand_bits(8);
         a  = {22'd0, r[7:0], 2'b00};
         case (op)
            0: ifu_read(a, 1'b0);
            1: lsu_read(a);
            2: lsu_write(a, rand_bits(32), 4'(rand_bits(4)), AXI_OKAY, 1'b0);
            default: begin
               fork
                  ifu_read(a, 1'b0);
                  lsu_read(a ^ 32'h40);
               join
            end
         endcase
         wait_idle();
      end

      $display("Done: no errors");
      $finish;
   end

endmodule

`default_nettype wire

// File: flist.f
+incdir+rtl
rtl/biu_pkg.sv
rtl/biu_chan_reg.sv
rtl/biu_rd_router.sv
rtl/biu_wr_fsm.sv
rtl/biu_wait_timer.sv
rtl/biu_top.sv
sim/axi_slave_model.sv
sim/biu_tb.sv

// File: run_sim.sh
#!/bin/sh
# builds the testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f flist.f --top-module biu_tb -o biu_sim

# the log is searched afterwards, so a fatal stop must not end the script here
./obj_dir/biu_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Done: errors found" sim.log; then
   echo "simulation FAILED"
   exit 1
fi
if ! grep -q "Done: no errors" sim.log; then
   echo "simulation ended without a result"
   exit 1
fi
echo "simulation passed"
